// File: verilog/lcd_i2c_pkg.sv
`default_nettype none

// Shared definitions for the LCD I2C link
package lcd_i2c_pkg;

    // Width of one display value as written by the display controller
    localparam int LCD_DATA_W = 6;

    // Width of one byte on the I2C bus
    localparam int I2C_BYTE_W = 8;

    // Zero bits appended below the display value to fill a bus byte
    localparam int PAD_W = I2C_BYTE_W - LCD_DATA_W;

    // Bus FSM states, in the order a transaction walks through them
    typedef enum logic [2:0] {
        OFF   = 3'd0,   // Bus idle, SCL and SDA high
        START = 3'd1,   // START condition
        SEND  = 3'd2,   // Eight data bits, MSB first
        ACK   = 3'd3,   // SDA released, slave acknowledge sampled
        STOP  = 3'd4    // STOP condition
    } i2c_state_e;

endpackage

`default_nettype wire

// File: verilog/lcd_write_queue.sv
`default_nettype none
`timescale 1ns/10ps

module lcd_write_queue #(
    parameter int QUEUE_DEPTH     = 4,   // Must be a power of two
    parameter int BYTES_PER_TRANS = 2
) (
    input  logic                                clk,
    input  logic                                rst,
    input  logic                                wr_i,
    input  logic [lcd_i2c_pkg::LCD_DATA_W-1:0]  wr_data_i,
    input  logic                                master_busy_i,
    input  logic                                next_pulse_i,
    input  logic                                trans_done_i,
    output logic                                full_o,
    output logic                                start_req_o,
    output logic [lcd_i2c_pkg::LCD_DATA_W-1:0]  tx_data_o
);

    localparam int PTR_W = $clog2(QUEUE_DEPTH);
    localparam int CNT_W = PTR_W + 1;
    localparam int POP_W = $clog2(BYTES_PER_TRANS + 1);

    logic [lcd_i2c_pkg::LCD_DATA_W-1:0] mem [QUEUE_DEPTH];

    logic [PTR_W-1:0] wr_ptr_q;
    logic [PTR_W-1:0] rd_ptr_q;
    logic [CNT_W-1:0] count_q;
    logic [POP_W-1:0] pop_cnt_q;        // Bytes popped in the running transaction
    logic             wr_accept;
    logic [CNT_W-1:0] pop_amount;

    assign full_o    = (count_q == CNT_W'(QUEUE_DEPTH));
    assign wr_accept = wr_i && !full_o;    // Writes while full are lost
    assign tx_data_o = mem[rd_ptr_q];

    // A whole transaction must be waiting before the master is started.
    // The done pulse is masked so a stale count is never seen on the
    // cycle the master returns to idle.
    assign start_req_o = (count_q >= CNT_W'(BYTES_PER_TRANS))
                         && !master_busy_i
                         && !trans_done_i;

    always_comb begin
        pop_amount = '0;
        if (next_pulse_i) begin
            pop_amount = CNT_W'(1);            // Head taken by the master
        end else if (trans_done_i) begin
            // Zero after a clean transaction, the unsent rest after a NACK
            pop_amount = CNT_W'(BYTES_PER_TRANS) - CNT_W'(pop_cnt_q);
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wr_ptr_q  <= '0;
            rd_ptr_q  <= '0;
            count_q   <= '0;
            pop_cnt_q <= '0;
        end else begin
            if (wr_accept) begin
                wr_ptr_q <= wr_ptr_q + 1'b1;
            end
            rd_ptr_q <= rd_ptr_q + PTR_W'(pop_amount);   // Wraps with the buffer
            count_q  <= count_q + CNT_W'(wr_accept) - pop_amount;
            if (trans_done_i) begin
                pop_cnt_q <= '0;
            end else if (next_pulse_i) begin
                pop_cnt_q <= pop_cnt_q + 1'b1;
            end
        end
    end

    // Storage
    always_ff @(posedge clk) begin
        if (wr_accept) begin
            mem[wr_ptr_q] <= wr_data_i;
        end
    end

endmodule

`default_nettype wire

// File: verilog/scl_tick_gen.sv
`default_nettype none
`timescale 1ns/10ps

module scl_tick_gen #(
    parameter int TICK_DIV = 512   // clk cycles per bus tick
) (
    input  logic clk,
    input  logic rst,
    output logic tick_o
);

    localparam int CNT_W = (TICK_DIV > 1) ? $clog2(TICK_DIV) : 1;

    logic [CNT_W-1:0] count_q;

    // Free running divider, tick_o is high for one clk on each wrap
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            count_q <= '0;
            tick_o  <= 1'b0;
        end else if (count_q == CNT_W'(TICK_DIV - 1)) begin
            count_q <= '0;
            tick_o  <= 1'b1;
        end else begin
            count_q <= count_q + 1'b1;
            tick_o  <= 1'b0;
        end
    end

endmodule

`default_nettype wire

// File: verilog/i2c_byte_master.sv
`default_nettype none
`timescale 1ns/10ps

module i2c_byte_master #(
    parameter int BYTES_PER_TRANS = 2
) (
    input  logic                                clk,
    input  logic                                rst,
    input  logic                                tick_i,
    input  logic                                start_req_i,
    input  logic [lcd_i2c_pkg::LCD_DATA_W-1:0]  tx_data_i,
    input  logic                                sda_i,
    output logic                                sda_o,
    output logic                                scl_o,
    output logic                                oeb_o,
    output logic                                busy_o,
    output logic                                next_pulse_o,
    output logic                                trans_done_o,
    output logic                                comms_error_o
);

    localparam int BYTE_W      = lcd_i2c_pkg::I2C_BYTE_W;
    localparam int START_STEPS = 4;
    localparam int SEND_STEPS  = BYTE_W * 4;    // Four ticks per bit
    localparam int ACK_STEPS   = 5;
    localparam int STOP_STEPS  = 4;
    localparam int STEP_W      = $clog2(SEND_STEPS);
    localparam int BCNT_W      = $clog2(BYTES_PER_TRANS + 1);

    lcd_i2c_pkg::i2c_state_e state_q;
    lcd_i2c_pkg::i2c_state_e state_n;

    logic [STEP_W-1:0] step_q;        // Tick count inside the current phase
    logic [STEP_W-1:0] step_n;
    logic [BYTE_W-1:0] shreg_q;       // Byte being shifted out, MSB first
    logic [BYTE_W-1:0] shreg_n;
    logic [BCNT_W-1:0] byte_cnt_q;    // Bytes loaded in this transaction
    logic [BCNT_W-1:0] byte_cnt_n;
    logic              ack_q;
    logic              ack_n;
    logic              sda_n;
    logic              scl_n;
    logic              oeb_n;
    logic              load_byte;     // Head entry taken into the shift register
    logic              err_n;
    logic              done_n;

    assign busy_o = (state_q != lcd_i2c_pkg::OFF);

    always_comb begin
        state_n    = state_q;
        step_n     = step_q;
        shreg_n    = shreg_q;
        byte_cnt_n = byte_cnt_q;
        ack_n      = ack_q;
        sda_n      = sda_o;
        scl_n      = scl_o;
        oeb_n      = oeb_o;
        load_byte  = 1'b0;
        err_n      = 1'b0;
        done_n     = 1'b0;

        if (tick_i) begin
            step_n = step_q + 1'b1;
            case (state_q)
                lcd_i2c_pkg::OFF: begin
                    sda_n  = 1'b1;             // Idle bus
                    scl_n  = 1'b1;
                    step_n = '0;
                    if (start_req_i) begin
                        state_n    = lcd_i2c_pkg::START;
                        byte_cnt_n = '0;
                    end
                end
                lcd_i2c_pkg::START: begin
                    ack_n = 1'b0;
                    case (step_q[1:0])
                        2'd0: sda_n = 1'b1;
                        2'd1: begin
                            sda_n = 1'b1;
                            scl_n = 1'b1;
                        end
                        2'd2: sda_n = 1'b0;    // SDA falls while SCL high
                        default: scl_n = 1'b0;
                    endcase
                    if (step_q == STEP_W'(START_STEPS - 1)) begin
                        state_n    = lcd_i2c_pkg::SEND;
                        step_n     = '0;
                        shreg_n    = {tx_data_i, {lcd_i2c_pkg::PAD_W{1'b0}}};
                        load_byte  = 1'b1;
                        byte_cnt_n = byte_cnt_q + 1'b1;
                    end
                end
                lcd_i2c_pkg::SEND: begin
                    if (step_q[1:0] == 2'd0) begin
                        sda_n   = shreg_q[BYTE_W-1];   // Data moves only with SCL low
                        shreg_n = shreg_q << 1;
                        scl_n   = 1'b0;
                    end else if (step_q[1:0] == 2'd3) begin
                        scl_n = 1'b0;
                    end else begin
                        scl_n = 1'b1;
                    end
                    if (step_q == STEP_W'(SEND_STEPS - 1)) begin
                        state_n = lcd_i2c_pkg::ACK;
                        step_n  = '0;
                    end
                end
                lcd_i2c_pkg::ACK: begin
                    oeb_n = 1'b1;                      // Slave owns SDA
                    if (scl_o && !sda_i) begin
                        ack_n = 1'b1;                  // Acknowledge is SDA low
                    end
                    scl_n = (step_q == STEP_W'(1)) || (step_q == STEP_W'(2));
                    if (step_q == STEP_W'(ACK_STEPS - 1)) begin
                        oeb_n  = 1'b0;
                        ack_n  = 1'b0;
                        step_n = '0;
                        if (ack_q && (byte_cnt_q < BCNT_W'(BYTES_PER_TRANS))) begin
                            state_n    = lcd_i2c_pkg::SEND;
                            shreg_n    = {tx_data_i, {lcd_i2c_pkg::PAD_W{1'b0}}};
                            load_byte  = 1'b1;
                            byte_cnt_n = byte_cnt_q + 1'b1;
                        end else begin
                            state_n = lcd_i2c_pkg::STOP;
                            err_n   = !ack_q;          // NACK cuts the transaction short
                        end
                    end
                end
                lcd_i2c_pkg::STOP: begin
                    case (step_q[1:0])
                        2'd0, 2'd1: begin
                            sda_n = 1'b0;
                            scl_n = 1'b0;
                        end
                        2'd2: scl_n = 1'b1;
                        default: sda_n = 1'b1;         // SDA rises while SCL high
                    endcase
                    if (step_q == STEP_W'(STOP_STEPS - 1)) begin
                        state_n = lcd_i2c_pkg::OFF;
                        step_n  = '0;
                        done_n  = 1'b1;
                    end
                end
                default: begin
                    state_n = lcd_i2c_pkg::OFF;
                    step_n  = '0;
                end
            endcase
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state_q       <= lcd_i2c_pkg::OFF;
            step_q        <= '0;
            byte_cnt_q    <= '0;
            ack_q         <= 1'b0;
            sda_o         <= 1'b1;
            scl_o         <= 1'b1;
            oeb_o         <= 1'b0;
            next_pulse_o  <= 1'b0;
            trans_done_o  <= 1'b0;
            comms_error_o <= 1'b0;
        end else begin
            state_q       <= state_n;
            step_q        <= step_n;
            byte_cnt_q    <= byte_cnt_n;
            ack_q         <= ack_n;
            sda_o         <= sda_n;
            scl_o         <= scl_n;
            oeb_o         <= oeb_n;
            next_pulse_o  <= load_byte;    // Queue pops the cycle after the load
            trans_done_o  <= done_n;
            comms_error_o <= err_n;
        end
    end

    always_ff @(posedge clk) begin
        shreg_q <= shreg_n;
    end

endmodule

`default_nettype wire

// File: verilog/lcd_i2c_top.sv
`default_nettype none
`timescale 1ns/10ps

module lcd_i2c_top #(
    parameter int TICK_DIV        = 512,
    parameter int BYTES_PER_TRANS = 2,
    parameter int QUEUE_DEPTH     = 4
) (
    input  logic                                clk,
    input  logic                                rst,
    input  logic                                wr_i,
    input  logic [lcd_i2c_pkg::LCD_DATA_W-1:0]  wr_data_i,
    input  logic                                sda_i,
    output logic                                full_o,
    output logic                                busy_o,
    output logic                                comms_error_o,
    output logic                                sda_o,
    output logic                                scl_o,
    output logic                                oeb_o
);

    logic                               start_req;
    logic [lcd_i2c_pkg::LCD_DATA_W-1:0] tx_data;
    logic                               next_pulse;
    logic                               trans_done;
    logic                               tick;

    lcd_write_queue #(
        .QUEUE_DEPTH     (QUEUE_DEPTH),
        .BYTES_PER_TRANS (BYTES_PER_TRANS)
    ) u_queue (
        .clk           (clk),
        .rst           (rst),
        .wr_i          (wr_i),
        .wr_data_i     (wr_data_i),
        .master_busy_i (busy_o),      // Master idle gates the start request
        .next_pulse_i  (next_pulse),
        .trans_done_i  (trans_done),
        .full_o        (full_o),
        .start_req_o   (start_req),
        .tx_data_o     (tx_data)
    );

    scl_tick_gen #(
        .TICK_DIV (TICK_DIV)
    ) u_tick (
        .clk    (clk),
        .rst    (rst),
        .tick_o (tick)
    );

    i2c_byte_master #(
        .BYTES_PER_TRANS (BYTES_PER_TRANS)
    ) u_master (
        .clk           (clk),
        .rst           (rst),
        .tick_i        (tick),
        .start_req_i   (start_req),
        .tx_data_i     (tx_data),
        .sda_i         (sda_i),
        .sda_o         (sda_o),
        .scl_o         (scl_o),
        .oeb_o         (oeb_o),
        .busy_o        (busy_o),
        .next_pulse_o  (next_pulse),
        .trans_done_o  (trans_done),
        .comms_error_o (comms_error_o)
    );

endmodule

`default_nettype wire

// File: tb/lcd_i2c_assertions.sv
`default_nettype none
`timescale 1ns/10ps

module lcd_i2c_assertions (
    input logic                    clk,
    input logic                    rst,
    input logic                    bus_scl_i,
    input logic                    bus_sda_i,
    input logic                    oeb_i,
    input logic                    busy_i,
    input logic                    comms_error_i,
    input lcd_i2c_pkg::i2c_state_e state_i
);

    int fail_count = 0;   // Failed properties so far

    // SDA moves only while SCL holds still
    scl_sda_apart: assert property (@(posedge clk) disable iff (rst)
        (busy_i && !$stable(bus_scl_i)) |-> $stable(bus_sda_i))
        else begin
            $error("SCL and SDA changed on the same clk cycle");
            fail_count++;
        end

    // The master lets go of SDA only for the acknowledge slot
    oeb_in_ack: assert property (@(posedge clk) disable iff (rst)
        oeb_i |-> (state_i == lcd_i2c_pkg::ACK))
        else begin
            $error("oeb_o high outside the ACK state");
            fail_count++;
        end

    error_one_cycle: assert property (@(posedge clk) disable iff (rst)
        $rose(comms_error_i) |=> !comms_error_i)
        else begin
            $error("comms_error_o held for more than one cycle");
            fail_count++;
        end

endmodule

bind i2c_byte_master lcd_i2c_assertions u_assert (
    .clk           (clk),
    .rst           (rst),
    .bus_scl_i     (scl_o),
    .bus_sda_i     (sda_o),
    .oeb_i         (oeb_o),
    .busy_i        (busy_o),
    .comms_error_i (comms_error_o),
    .state_i       (state_q)
);

`default_nettype wire

// File: tb/lcd_i2c_tb.sv
`default_nettype none
`timescale 1ns/10ps

module lcd_i2c_tb;

    localparam int WAIT_LIMIT = 2000;   // clk cycles allowed for one wait
    localparam int PAD_W      = lcd_i2c_pkg::PAD_W;

    logic        clk;
    logic        rst;
    logic        wr_i;
    logic [5:0]  wr_data_i;
    logic        sda_i;
    logic        full_o;
    logic        busy_o;
    logic        comms_error_o;
    logic        sda_o;
    logic        scl_o;
    logic        oeb_o;

    logic        sda_line;              // SDA wire as the slave sees it
    logic        prev_scl = 1'b1;
    logic        prev_sda = 1'b1;
    logic [7:0]  shift_reg = 8'h00;
    int          bit_cnt = 0;
    int          trans_byte = 0;        // Bytes received since the last START
    int          nack_on_byte = -1;     // Byte index in a transaction left without ACK
    int          start_cnt = 0;
    int          stop_cnt = 0;
    int          err_pulses = 0;
    int          errors = 0;
    int          checks = 0;
    int          tests = 0;
    logic [31:0] rng_state = 32'hc203;
    logic [7:0]  rx_bytes [$];
    logic [5:0]  sent_q [$];            // Values the bus must carry, in order

    lcd_i2c_top #(.TICK_DIV(4)) uut (
        .clk           (clk),
        .rst           (rst),
        .wr_i          (wr_i),
        .wr_data_i     (wr_data_i),
        .sda_i         (sda_i),
        .full_o        (full_o),
        .busy_o        (busy_o),
        .comms_error_o (comms_error_o),
        .sda_o         (sda_o),
        .scl_o         (scl_o),
        .oeb_o         (oeb_o)
    );

    always #50 clk = ~clk;

    assign sda_line = oeb_o ? sda_i : sda_o;
    assign sda_i    = oeb_o ? (nack_on_byte == trans_byte - 1) : 1'b1;   // Low is ACK

    // I2C slave, samples the bus mid-cycle
    always @(negedge clk) begin
        if (scl_o && prev_scl && prev_sda && !sda_line) begin
            start_cnt++;
            bit_cnt    = 0;
            trans_byte = 0;
        end else if (scl_o && prev_scl && !prev_sda && sda_line) begin
            stop_cnt++;
        end else if (scl_o && !prev_scl && !oeb_o) begin
            shift_reg = {shift_reg[6:0], sda_line};   // MSB first
            bit_cnt++;
            if (bit_cnt == 8) begin
                rx_bytes.push_back(shift_reg);
                bit_cnt = 0;
                trans_byte++;
            end
        end
        if (comms_error_o) begin
            err_pulses++;
        end
        prev_scl = scl_o;
        prev_sda = sda_line;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] seed);
        logic [31:0] x;
        x = seed;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [7:0] padded(input logic [5:0] value);
        return 8'(value) << PAD_W;   // Zero LSBs below the display value
    endfunction

    task automatic apply_reset();
        rst = 1'b1;
        repeat (4) @(posedge clk);
        #1;
        rst = 1'b0;
    endtask

    task automatic write_value(input logic [5:0] value);
        wr_i      = 1'b1;
        wr_data_i = value;
        @(posedge clk);
        #1;
        wr_i = 1'b0;
    endtask

    task automatic wait_busy(input logic level, input string what);
        int cycles;
        cycles = 0;
        while (busy_o !== level && cycles < WAIT_LIMIT) begin
            @(posedge clk);
            #1;
            cycles++;
        end
        if (busy_o !== level) begin
            $display("Timeout at %0t: busy_o never went to %0b during %s", $time, level, what);
            errors++;
        end
    endtask

    task automatic wait_transaction(input string what);
        wait_busy(1'b1, what);
        wait_busy(1'b0, what);
        repeat (2) @(posedge clk);   // Slave sees the STOP on the next negedge
        #1;
    endtask

    task automatic check_byte(input string what, input logic [7:0] got, input logic [7:0] exp);
        checks++;
        if (got !== exp) begin
            $display("CHECK FAILED at %0t: %s got %02h expected %02h", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic check_value(input string what, input logic [5:0] got, input logic [5:0] exp);
        checks++;
        if (got !== exp) begin
            $display("CHECK FAILED at %0t: %s got %02h expected %02h", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic check_flag(input string what, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            $display("CHECK FAILED at %0t: %s got %0b expected %0b", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic check_rx_history(input string what);
        check_flag({what, " byte count"}, rx_bytes.size() == sent_q.size(), 1'b1);
        for (int i = 0; i < rx_bytes.size() && i < sent_q.size(); i++) begin
            check_byte($sformatf("%s byte %0d", what, i), rx_bytes[i], padded(sent_q[i]));
        end
    endtask

    task automatic report_test(input string name, input int e0);
        tests++;
        if (errors == e0) begin
            $display("%s: ok", name);
        end else begin
            $display("%s: %0d error(s)", name, errors - e0);
        end
    endtask

    task automatic test_reset_state();
        int   e0;
        logic saw_busy;
        e0 = errors;
        check_flag("scl_o after reset", scl_o, 1'b1);
        check_flag("sda_o after reset", sda_o, 1'b1);
        check_flag("oeb_o after reset", oeb_o, 1'b0);
        check_flag("busy_o after reset", busy_o, 1'b0);
        check_flag("full_o after reset", full_o, 1'b0);
        check_flag("comms_error_o after reset", comms_error_o, 1'b0);
        write_value(6'h15);
        saw_busy = 1'b0;
        repeat (100) begin   // 25 ticks, well past any START
            @(posedge clk);
            #1;
            saw_busy = saw_busy | busy_o;
        end
        check_flag("busy_o with one queued write", saw_busy, 1'b0);
        apply_reset();       // Drop the lone entry
        report_test("reset_state", e0);
    endtask

    task automatic test_one_transaction();
        int e0;
        int s0;
        int p0;
        int r0;
        e0 = errors;
        s0 = start_cnt;
        p0 = stop_cnt;
        r0 = err_pulses;
        write_value(6'h2a);
        sent_q.push_back(6'h2a);
        write_value(6'h07);
        sent_q.push_back(6'h07);
        wait_transaction("one transaction");
        check_flag("one START", start_cnt - s0 == 1, 1'b1);
        check_flag("one STOP", stop_cnt - p0 == 1, 1'b1);
        check_flag("busy_o after STOP", busy_o, 1'b0);
        check_flag("no error pulse", err_pulses == r0, 1'b1);
        check_rx_history("one transaction");
        report_test("one_transaction", e0);
    endtask

    task automatic test_nack_first_byte();
        int e0;
        int p0;
        int r0;
        e0 = errors;
        p0 = stop_cnt;
        r0 = err_pulses;
        nack_on_byte = 0;
        write_value(6'h3c);
        sent_q.push_back(6'h3c);   // Second byte must never reach the bus
        write_value(6'h11);
        wait_transaction("NACK transaction");
        check_flag("one error pulse at NACK", err_pulses - r0 == 1, 1'b1);
        check_flag("STOP after NACK", stop_cnt - p0 == 1, 1'b1);
        check_rx_history("after NACK");
        nack_on_byte = -1;
        write_value(6'h09);
        sent_q.push_back(6'h09);
        write_value(6'h32);
        sent_q.push_back(6'h32);
        wait_transaction("transaction after NACK");
        check_flag("no new error pulse", err_pulses - r0 == 1, 1'b1);
        check_rx_history("after recovery");
        report_test("nack_first_byte", e0);
    endtask

    task automatic test_full_queue();
        int e0;
        int n;
        e0 = errors;
        write_value(6'h01);
        write_value(6'h3e);
        write_value(6'h10);
        write_value(6'h23);
        sent_q.push_back(6'h01);
        sent_q.push_back(6'h3e);
        sent_q.push_back(6'h10);
        sent_q.push_back(6'h23);
        check_flag("full_o after four writes", full_o, 1'b1);
        write_value(6'h3f);        // Dropped
        wait_transaction("first of two");
        wait_transaction("second of two");
        check_flag("full_o after draining", full_o, 1'b0);
        check_rx_history("full queue");
        n = rx_bytes.size();
        for (int i = 0; i < 4 && n >= 4; i++) begin
            check_value($sformatf("unpadded value %0d", i),
                        6'(rx_bytes[n - 4 + i] >> PAD_W), sent_q[sent_q.size() - 4 + i]);
        end
        report_test("full_queue", e0);
    endtask

    task automatic test_random_pairs();
        int e0;
        int r0;
        e0 = errors;
        r0 = err_pulses;
        for (int pair = 0; pair < 4; pair++) begin
            repeat (2) begin
                rng_state = xorshift32(rng_state);
                write_value(rng_state[5:0]);
                sent_q.push_back(rng_state[5:0]);
            end
            wait_transaction("random pair");
        end
        check_flag("no error pulse in random pairs", err_pulses == r0, 1'b1);
        check_rx_history("random pairs");
        report_test("random_pairs", e0);
    endtask

    initial begin
        clk       = 1'b0;
        rst       = 1'b1;
        wr_i      = 1'b0;
        wr_data_i = 6'h00;
        apply_reset();
        test_reset_state();
        test_one_transaction();
        test_nack_first_byte();
        test_full_queue();
        test_random_pairs();
        errors = errors + uut.u_master.u_assert.fail_count;
        $display("Tests: %0d  checks: %0d  errors: %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: flist.f
verilog/lcd_i2c_pkg.sv
verilog/lcd_write_queue.sv
verilog/scl_tick_gen.sv
verilog/i2c_byte_master.sv
verilog/lcd_i2c_top.sv
tb/lcd_i2c_assertions.sv
tb/lcd_i2c_tb.sv

// File: Makefile
TOP = lcd_i2c_tb

sim:
	verilator --binary --timing --assert --timescale 1ns/10ps --top-module $(TOP) -f flist.f -o $(TOP)
	./obj_dir/$(TOP) | tee /dev/stderr | grep -q "TESTBENCH PASSED"

clean:
	rm -rf obj_dir

.PHONY: sim clean
